//--- Makefile
VERILATOR  ?= verilator
FILELIST   ?= filelist.f
TOP        ?= ooo_core_tb
RTL_TOP    ?= ooo_core
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert
PASS_TEXT  ?= All checks passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- filelist.f
hdl/lc3b_pkg.sv
hdl/issue_if.sv
hdl/issue_control.sv
hdl/alu_res_station.sv
hdl/reorder_buffer.sv
hdl/regfile.sv
hdl/ooo_core.sv
testbench/ooo_core_tb.sv

//--- hdl/alu_res_station.sv
`timescale 1ns/1ps

module alu_res_station
	import lc3b_pkg::*;
#(
	parameter int NUM_RS = NUM_RS_DEF
)
(
	input  logic              clk,
	input  logic              rst_n,
	issue_if.station          iss,
	output logic [NUM_RS-1:0] rs_busy,
	output cdb_t              cdb
);

	localparam int IDX_W = (NUM_RS > 1) ? $clog2(NUM_RS) : 1;

	// Station state
	logic [NUM_RS-1:0] busy_q;
	logic [NUM_RS-1:0] qj_valid_q;
	logic [NUM_RS-1:0] qk_valid_q;
	lc3b_opcode        op_q [NUM_RS];
	lc3b_word          vj_q [NUM_RS];
	lc3b_word          vk_q [NUM_RS];
	rob_tag_t          qj_q [NUM_RS];
	rob_tag_t          qk_q [NUM_RS];
	rob_tag_t          dest_q [NUM_RS];

	logic [NUM_RS-1:0] load;
	logic [NUM_RS-1:0] hit_j;
	logic [NUM_RS-1:0] hit_k;
	logic [NUM_RS-1:0] ready;
	logic              pick_valid;
	logic [IDX_W-1:0]  pick_idx;
	lc3b_word          alu_a;
	lc3b_word          alu_b;
	lc3b_word          alu_out;

	logic              cdb_valid_q;
	rob_tag_t          cdb_tag_q;
	lc3b_word          cdb_value_q;

	// Issue writes and CDB snoop matches per station
	always_comb
	begin
		for (int i = 0; i < NUM_RS; i++)
		begin
			load[i]  = iss.valid & iss.rs_sel[i];
			hit_j[i] = cdb.valid & qj_valid_q[i] & (cdb.tag == qj_q[i]);
			hit_k[i] = cdb.valid & qk_valid_q[i] & (cdb.tag == qk_q[i]);
		end
	end

	assign ready      = busy_q & ~qj_valid_q & ~qk_valid_q;
	assign pick_valid = |ready;

	// Lowest-numbered ready station wins
	always_comb
	begin
		pick_idx = '0;
		for (int i = NUM_RS - 1; i >= 0; i--)
		begin
			if (ready[i])
				pick_idx = IDX_W'(i);
		end
	end

	assign alu_a = vj_q[pick_idx];
	assign alu_b = vk_q[pick_idx];

	always_comb
	begin
		case (op_q[pick_idx])
			op_and:  alu_out = alu_a & alu_b;
			op_not:  alu_out = alu_a ^ alu_b;
			default: alu_out = alu_a + alu_b;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy_q      <= '0;
			qj_valid_q  <= '0;
			qk_valid_q  <= '0;
			cdb_valid_q <= 1'b0;
		end
		else
		begin
			cdb_valid_q <= pick_valid;
			for (int i = 0; i < NUM_RS; i++)
			begin
				if (load[i])
				begin
					busy_q[i]     <= 1'b1;
					qj_valid_q[i] <= iss.qj_valid;
					qk_valid_q[i] <= iss.qk_valid;
				end
				else
				begin
					// Freed at the edge its result goes onto the CDB
					if (pick_valid && pick_idx == IDX_W'(i))
						busy_q[i] <= 1'b0;
					if (hit_j[i])
						qj_valid_q[i] <= 1'b0;
					if (hit_k[i])
						qk_valid_q[i] <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < NUM_RS; i++)
		begin
			if (load[i])
			begin
				op_q[i]   <= iss.op;
				vj_q[i]   <= iss.vj;
				vk_q[i]   <= iss.vk;
				qj_q[i]   <= iss.qj;
				qk_q[i]   <= iss.qk;
				dest_q[i] <= iss.dest;
			end
			else
			begin
				if (hit_j[i])
					vj_q[i] <= cdb.value;
				if (hit_k[i])
					vk_q[i] <= cdb.value;
			end
		end
		if (pick_valid)
		begin
			cdb_tag_q   <= dest_q[pick_idx];
			cdb_value_q <= alu_out;
		end
	end

	assign cdb     = '{valid: cdb_valid_q, tag: cdb_tag_q, value: cdb_value_q};
	assign rs_busy = busy_q;

	// Issue never lands on a station still in use
	assert property (@(posedge clk) disable iff (!rst_n)
		iss.valid |-> ((iss.rs_sel & busy_q) == '0));

	// Each broadcast follows a selection whose station was freed at the same edge
	assert property (@(posedge clk) disable iff (!rst_n)
		cdb.valid |-> ($past(pick_valid) && !busy_q[$past(pick_idx)]));

endmodule : alu_res_station

//--- hdl/issue_control.sv
`timescale 1ns/1ps

module issue_control
	import lc3b_pkg::*;
#(
	parameter int ROB_DEPTH = ROB_DEPTH_DEF,
	parameter int NUM_RS    = NUM_RS_DEF
)
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              instr_valid,
	input  lc3b_word          instr,
	input  cdb_t              cdb,
	input  logic [NUM_RS-1:0] rs_busy,
	input  logic              rob_full,
	input  rob_tag_t          rob_tail,
	input  logic              rob_ready1,
	input  logic              rob_ready2,
	input  lc3b_word          rob_value1,
	input  lc3b_word          rob_value2,
	input  lc3b_word          sr1_value,
	input  lc3b_word          sr2_value,
	input  logic              sr1_busy,
	input  logic              sr2_busy,
	input  rob_tag_t          sr1_tag,
	input  rob_tag_t          sr2_tag,
	output logic              stall,
	output logic              rob_alloc,
	output lc3b_reg           alloc_dest,
	output rob_tag_t          rob_lookup1,
	output rob_tag_t          rob_lookup2,
	output lc3b_reg           sr1,
	output lc3b_reg           sr2,
	output logic              rename,
	output lc3b_reg           rename_dest,
	issue_if.issue            iss
);

	lc3b_opcode        op;
	lc3b_reg           dr;
	logic              bit5;
	lc3b_word          imm5_sext;
	logic              accept;
	logic [NUM_RS-1:0] free_sel;

	// Instruction fields
	assign op        = lc3b_opcode'(instr[15:12]);
	assign dr        = instr[11:9];
	assign sr1       = instr[8:6];
	assign sr2       = instr[2:0];
	assign bit5      = instr[5];
	assign imm5_sext = {{11{instr[4]}}, instr[4:0]};

	// Lowest-numbered free station
	always_comb
	begin
		free_sel = '0;
		for (int i = NUM_RS - 1; i >= 0; i--)
		begin
			if (!rs_busy[i])
			begin
				free_sel    = '0;
				free_sel[i] = 1'b1;
			end
		end
	end

	assign stall  = rob_full | (&rs_busy);
	assign accept = instr_valid & ~stall;

	// Allocation and rename of the destination
	assign rob_alloc   = accept;
	assign alloc_dest  = dr;
	assign rename      = accept;
	assign rename_dest = dr;
	assign rob_lookup1 = sr1_tag;
	assign rob_lookup2 = sr2_tag;

	assign iss.valid  = accept;
	assign iss.rs_sel = free_sel;
	assign iss.op     = op;
	assign iss.dest   = rob_tail;

	// First source: CDB, then finished ROB entry, then wait on the tag
	always_comb
	begin
		iss.vj       = sr1_value;
		iss.qj_valid = 1'b0;
		iss.qj       = sr1_tag;
		if (sr1_busy)
		begin
			if (cdb.valid && cdb.tag == sr1_tag)
				iss.vj = cdb.value;
			else if (rob_ready1)
				iss.vj = rob_value1;
			else
				iss.qj_valid = 1'b1;
		end
	end

	// Second source; NOT becomes an XOR with all ones
	always_comb
	begin
		iss.vk       = sr2_value;
		iss.qk_valid = 1'b0;
		iss.qk       = sr2_tag;
		if (op == op_not)
			iss.vk = 16'hffff;
		else if (bit5)
			iss.vk = imm5_sext;
		else if (sr2_busy)
		begin
			if (cdb.valid && cdb.tag == sr2_tag)
				iss.vk = cdb.value;
			else if (rob_ready2)
				iss.vk = rob_value2;
			else
				iss.qk_valid = 1'b1;
		end
	end

	// Only ADD, AND and NOT may enter the core
	assert property (@(posedge clk) disable iff (!rst_n)
		accept |-> (instr[15:12] inside {op_add, op_and, op_not}))
	else
		$error("issue_control: unsupported opcode %h accepted", instr[15:12]);

	// Each allocation takes the next tag in circular order
	assert property (@(posedge clk) disable iff (!rst_n)
		rob_alloc |=> (int'(rob_tail) == ((int'($past(rob_tail)) + 1) % ROB_DEPTH)));

endmodule : issue_control

//--- hdl/issue_if.sv
`timescale 1ns/1ps

interface issue_if
	import lc3b_pkg::*;
#(
	parameter int NUM_RS = NUM_RS_DEF
)
();
	logic              valid;
	logic [NUM_RS-1:0] rs_sel;
	lc3b_opcode        op;
	lc3b_word          vj;
	lc3b_word          vk;
	logic              qj_valid;
	logic              qk_valid;
	rob_tag_t          qj;
	rob_tag_t          qk;
	rob_tag_t          dest;

	modport issue (output valid, rs_sel, op, vj, vk, qj_valid, qk_valid, qj, qk, dest);
	modport station (input valid, rs_sel, op, vj, vk, qj_valid, qk_valid, qj, qk, dest);

endinterface : issue_if

//--- hdl/lc3b_pkg.sv
package lc3b_pkg;

	// Data word and architectural register index
	typedef logic [15:0] lc3b_word;
	typedef logic [2:0]  lc3b_reg;

	// Reorder-buffer entry index, sized for up to eight entries
	typedef logic [2:0]  rob_tag_t;

	// Opcodes handled by the ALU stations
	typedef enum logic [3:0]
	{
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_not = 4'b1001
	} lc3b_opcode;

	// One result broadcast on the common data bus
	typedef struct packed
	{
		logic     valid;
		rob_tag_t tag;
		lc3b_word value;
	} cdb_t;

	// Default sizes
	localparam int ROB_DEPTH_DEF = 8;
	localparam int NUM_RS_DEF    = 3;

endpackage : lc3b_pkg

//--- hdl/ooo_core.sv
`timescale 1ns/1ps

module ooo_core
	import lc3b_pkg::*;
#(
	parameter int ROB_DEPTH = ROB_DEPTH_DEF,
	parameter int NUM_RS    = NUM_RS_DEF
)
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     instr_valid,
	input  lc3b_word instr,
	output logic     stall,
	output logic     commit_valid,
	output lc3b_reg  commit_dest,
	output lc3b_word commit_value
);

	cdb_t              cdb;
	logic [NUM_RS-1:0] rs_busy;

	// ROB side
	logic     rob_alloc;
	lc3b_reg  alloc_dest;
	logic     rob_full;
	rob_tag_t rob_tail;
	rob_tag_t rob_lookup1;
	rob_tag_t rob_lookup2;
	logic     rob_ready1;
	logic     rob_ready2;
	lc3b_word rob_value1;
	lc3b_word rob_value2;
	logic     retire;
	lc3b_reg  retire_dest;
	lc3b_word retire_value;
	rob_tag_t retire_tag;

	// Register file side
	lc3b_reg  sr1;
	lc3b_reg  sr2;
	lc3b_word sr1_value;
	lc3b_word sr2_value;
	logic     sr1_busy;
	logic     sr2_busy;
	rob_tag_t sr1_tag;
	rob_tag_t sr2_tag;
	logic     rename;
	lc3b_reg  rename_dest;

	issue_if #(.NUM_RS(NUM_RS)) iss_bus ();

	issue_control #(.ROB_DEPTH(ROB_DEPTH), .NUM_RS(NUM_RS)) issue_control
	(
		.clk, .rst_n, .instr_valid, .instr, .cdb, .rs_busy,
		.rob_full, .rob_tail, .rob_ready1, .rob_ready2, .rob_value1, .rob_value2,
		.sr1_value, .sr2_value, .sr1_busy, .sr2_busy, .sr1_tag, .sr2_tag,
		.stall, .rob_alloc, .alloc_dest, .rob_lookup1, .rob_lookup2,
		.sr1, .sr2, .rename, .rename_dest,
		.iss(iss_bus)
	);

	alu_res_station #(.NUM_RS(NUM_RS)) alu_res_station
	(
		.clk, .rst_n, .iss(iss_bus), .rs_busy, .cdb
	);

	reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) reorder_buffer
	(
		.clk, .rst_n, .alloc(rob_alloc), .alloc_dest, .cdb,
		.lookup1(rob_lookup1), .lookup2(rob_lookup2),
		.tail(rob_tail), .full(rob_full),
		.ready1(rob_ready1), .ready2(rob_ready2), .value1(rob_value1), .value2(rob_value2),
		.retire, .retire_dest, .retire_value, .retire_tag
	);

	// Destination is renamed to the tail tag allocated in the same cycle
	regfile regfile
	(
		.clk, .rst_n, .sr1, .sr2,
		.rename, .rename_dest, .rename_tag(rob_tail),
		.retire, .retire_dest, .retire_value, .retire_tag,
		.sr1_value, .sr2_value, .sr1_busy, .sr2_busy, .sr1_tag, .sr2_tag
	);

	assign commit_valid = retire;
	assign commit_dest  = retire_dest;
	assign commit_value = retire_value;

endmodule : ooo_core

//--- hdl/regfile.sv
`timescale 1ns/1ps

module regfile
	import lc3b_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  lc3b_reg  sr1,
	input  lc3b_reg  sr2,
	input  logic     rename,
	input  lc3b_reg  rename_dest,
	input  rob_tag_t rename_tag,
	input  logic     retire,
	input  lc3b_reg  retire_dest,
	input  lc3b_word retire_value,
	input  rob_tag_t retire_tag,
	output lc3b_word sr1_value,
	output lc3b_word sr2_value,
	output logic     sr1_busy,
	output logic     sr2_busy,
	output rob_tag_t sr1_tag,
	output rob_tag_t sr2_tag
);

	lc3b_word   value_q [8];
	rob_tag_t   tag_q [8];
	logic [7:0] busy_q;

	assign sr1_value = value_q[sr1];
	assign sr2_value = value_q[sr2];
	assign sr1_busy  = busy_q[sr1];
	assign sr2_busy  = busy_q[sr2];
	assign sr1_tag   = tag_q[sr1];
	assign sr2_tag   = tag_q[sr2];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy_q <= '0;
			for (int i = 0; i < 8; i++)
			begin
				value_q[i] <= '0;
				tag_q[i]   <= '0;
			end
		end
		else
		begin
			if (retire)
			begin
				value_q[retire_dest] <= retire_value;
				// Keep busy if a younger producer has renamed it since
				if (tag_q[retire_dest] == retire_tag)
					busy_q[retire_dest] <= 1'b0;
			end
			if (rename)
			begin
				busy_q[rename_dest] <= 1'b1;
				tag_q[rename_dest]  <= rename_tag;
			end
		end
	end

endmodule : regfile

//--- hdl/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer
	import lc3b_pkg::*;
#(
	parameter int ROB_DEPTH = ROB_DEPTH_DEF
)
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     alloc,
	input  lc3b_reg  alloc_dest,
	input  cdb_t     cdb,
	input  rob_tag_t lookup1,
	input  rob_tag_t lookup2,
	output rob_tag_t tail,
	output logic     full,
	output logic     ready1,
	output logic     ready2,
	output lc3b_word value1,
	output lc3b_word value2,
	output logic     retire,
	output lc3b_reg  retire_dest,
	output lc3b_word retire_value,
	output rob_tag_t retire_tag
);

	localparam rob_tag_t   LAST_TAG  = rob_tag_t'(ROB_DEPTH - 1);
	localparam logic [3:0] DEPTH_CNT = 4'(ROB_DEPTH);

	lc3b_reg              dest_q [ROB_DEPTH];
	lc3b_word             value_q [ROB_DEPTH];
	logic [ROB_DEPTH-1:0] done_q;
	rob_tag_t             head_q;
	rob_tag_t             tail_q;
	logic [3:0]           count_q;
	logic                 head_ready;
	logic [3:0]           cdb_offset;
	logic                 cdb_in_flight;

	assign head_ready = (count_q != 4'd0) && done_q[head_q];
	assign full       = (count_q == DEPTH_CNT);
	assign tail       = tail_q;

	// Done bits clear only on allocation, so a just-retired entry still answers
	// while its register write is in progress
	assign ready1 = done_q[lookup1];
	assign ready2 = done_q[lookup2];
	assign value1 = value_q[lookup1];
	assign value2 = value_q[lookup2];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
			done_q  <= '0;
			retire  <= 1'b0;
		end
		else
		begin
			retire <= head_ready;
			if (head_ready)
				head_q <= (head_q == LAST_TAG) ? '0 : head_q + 1'b1;
			if (alloc)
			begin
				tail_q         <= (tail_q == LAST_TAG) ? '0 : tail_q + 1'b1;
				done_q[tail_q] <= 1'b0;
			end
			if (cdb.valid)
				done_q[cdb.tag] <= 1'b1;
			count_q <= count_q + 4'(alloc) - 4'(head_ready);
		end
	end

	always_ff @(posedge clk)
	begin
		if (alloc)
			dest_q[tail_q] <= alloc_dest;
		if (cdb.valid)
			value_q[cdb.tag] <= cdb.value;
		// Commit port
		if (head_ready)
		begin
			retire_dest  <= dest_q[head_q];
			retire_value <= value_q[head_q];
			retire_tag   <= head_q;
		end
	end

	// Distance of the broadcast tag from the head
	assign cdb_offset = (cdb.tag >= head_q) ? 4'(cdb.tag) - 4'(head_q)
		: 4'(cdb.tag) + DEPTH_CNT - 4'(head_q);
	assign cdb_in_flight = (cdb_offset < count_q);

	// Station results only ever target a live, unfinished entry
	assert property (@(posedge clk) disable iff (!rst_n)
		cdb.valid |-> (cdb_in_flight && !done_q[cdb.tag]));

endmodule : reorder_buffer

//--- testbench/ooo_core_tb.sv
`timescale 1ns/1ps

module ooo_core_tb;

	localparam logic [3:0] OPC_ADD = 4'b0001;
	localparam logic [3:0] OPC_AND = 4'b0101;
	localparam logic [3:0] OPC_NOT = 4'b1001;

	// Instructions per test, used for the run limit
	localparam int N_IMM       = 16;
	localparam int N_CHAIN     = 32;
	localparam int N_MIX       = 64;
	localparam int N_ORDER     = 40;
	localparam int N_BURST     = 48;
	localparam int TOTAL_INSTR = N_IMM + N_CHAIN + N_MIX + N_ORDER + N_BURST;
	localparam int CYCLE_LIMIT = 20 * TOTAL_INSTR + 100;

	logic        clk;
	logic        rst_n;
	logic        instr_valid;
	logic [15:0] instr;
	logic        stall;
	logic        commit_valid;
	logic [2:0]  commit_dest;
	logic [15:0] commit_value;

	logic [16:0] lfsr;
	logic [15:0] ref_regs [8];
	logic [2:0]  exp_dest_q [$];
	logic [15:0] exp_value_q [$];
	logic [2:0]  exp_dest_head;
	logic [15:0] exp_value_head;
	int          exp_count;
	int          accepted;
	int          commits;
	int          errors;
	int          cycles;
	int          tests;
	int          err_mark;
	int          instr_mark;
	logic        idle_check;
	logic        stall_seen;

	ooo_core dut0
	(
		.clk, .rst_n, .instr_valid, .instr,
		.stall, .commit_valid, .commit_dest, .commit_value
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles with %0d commits outstanding", cycles, exp_count);
			$display("Checks failed");
			$finish;
		end
	end

	// 17-bit Fibonacci LFSR, taps 17 and 14
	function automatic logic lfsr_bit();
		logic out_bit;
		out_bit = lfsr[16];
		lfsr = {lfsr[15:0], lfsr[16] ^ lfsr[13]};
		return out_bit;
	endfunction

	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] val;
		val = '0;
		for (int i = 0; i < n; i++)
			val = {val[14:0], lfsr_bit()};
		return val;
	endfunction

	function automatic logic [15:0] enc_reg(input logic [3:0] op, input logic [2:0] dr,
		input logic [2:0] s1, input logic [2:0] s2);
		return {op, dr, s1, 3'b000, s2};
	endfunction

	function automatic logic [15:0] enc_imm(input logic [3:0] op, input logic [2:0] dr,
		input logic [2:0] s1, input logic [4:0] imm);
		return {op, dr, s1, 1'b1, imm};
	endfunction

	function automatic logic [15:0] enc_not(input logic [2:0] dr, input logic [2:0] s1);
		return {OPC_NOT, dr, s1, 6'b111111};
	endfunction

	function automatic void refresh_head();
		exp_count = exp_dest_q.size();
		if (exp_count != 0)
		begin
			exp_dest_head  = exp_dest_q[0];
			exp_value_head = exp_value_q[0];
		end
	endfunction

	// Sequential ISA model, one call per accepted instruction
	function automatic void model_apply(input logic [15:0] word);
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] res;
		a = ref_regs[word[8:6]];
		b = word[5] ? 16'($signed(word[4:0])) : ref_regs[word[2:0]];
		case (word[15:12])
			OPC_ADD: res = a + b;
			OPC_AND: res = a & b;
			default: res = ~a;
		endcase
		ref_regs[word[11:9]] = res;
		exp_dest_q.push_back(word[11:9]);
		exp_value_q.push_back(res);
		accepted++;
		refresh_head();
	endfunction

	// Hold the word until a cycle without stall takes it
	task automatic send_instr(input logic [15:0] word);
		logic taken;
		taken       = 1'b0;
		instr_valid = 1'b1;
		instr       = word;
		while (!taken)
		begin
			if (stall)
				stall_seen = 1'b1;
			else
			begin
				taken = 1'b1;
				model_apply(word);
			end
			@(posedge clk);
			#1;
		end
		instr_valid = 1'b0;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic wait_drain();
		while (exp_count != 0)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic report_test(input string name);
		tests++;
		$display("Test %0d %s: %0d instructions, %0d errors", tests, name,
			accepted - instr_mark, errors - err_mark);
		err_mark   = errors;
		instr_mark = accepted;
	endtask

	task automatic run_mix();
		logic [1:0] kind;
		logic [3:0] opc;
		logic       imm_form;
		logic [2:0] dr;
		logic [2:0] s1;
		logic [2:0] s2;
		for (int i = 0; i < N_MIX; i++)
		begin
			kind     = 2'(rand_bits(2));
			imm_form = 1'(rand_bits(1));
			dr       = 3'(rand_bits(3));
			s1       = 3'(rand_bits(3));
			s2       = 3'(rand_bits(3));
			opc      = (kind == 2'd2) ? OPC_AND : OPC_ADD;
			if (kind == 2'd3)
				send_instr(enc_not(dr, s1));
			else if (imm_form)
				send_instr(enc_imm(opc, dr, s1, 5'(rand_bits(5))));
			else
				send_instr(enc_reg(opc, dr, s1, s2));
			if (rand_bits(1) != 16'd0)
				wait_cycles(1);
		end
	endtask

	// Commits consumed mid-cycle where the outputs are stable
	always @(negedge clk)
	begin
		if (rst_n && commit_valid)
		begin
			commits++;
			if (exp_count != 0)
			begin
				void'(exp_dest_q.pop_front());
				void'(exp_value_q.pop_front());
				refresh_head();
			end
		end
	end

	assert property (@(negedge clk) disable iff (!rst_n)
		commit_valid |-> (exp_count != 0))
	else
	begin
		$display("Commit arrived with no instruction outstanding");
		errors++;
	end

	assert property (@(negedge clk) disable iff (!rst_n)
		(commit_valid && exp_count != 0) |-> (commit_dest == exp_dest_head))
	else
	begin
		$display("[ERROR] commit_dest got %h expected %h",
			$sampled(commit_dest), $sampled(exp_dest_head));
		errors++;
	end

	assert property (@(negedge clk) disable iff (!rst_n)
		(commit_valid && exp_count != 0) |-> (commit_value == exp_value_head))
	else
	begin
		$display("[ERROR] commit_value got %h expected %h",
			$sampled(commit_value), $sampled(exp_value_head));
		errors++;
	end

	assert property (@(negedge clk) disable iff (!rst_n)
		idle_check |-> (!commit_valid && !stall))
	else
	begin
		$display("[ERROR] commit_valid %h stall %h while idle",
			$sampled(commit_valid), $sampled(stall));
		errors++;
	end

	initial
	begin
		lfsr        = 17'd66440;
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		idle_check  = 1'b0;
		stall_seen  = 1'b0;
		exp_count   = 0;
		accepted    = 0;
		commits     = 0;
		errors      = 0;
		cycles      = 0;
		tests       = 0;
		err_mark    = 0;
		instr_mark  = 0;
		for (int r = 0; r < 8; r++)
			ref_regs[r] = '0;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;

		idle_check = 1'b1;
		wait_cycles(12);
		idle_check = 1'b0;
		report_test("reset state");

		for (int r = 0; r < 8; r++)
			send_instr(enc_imm(OPC_AND, 3'(r), 3'(r), 5'd0));
		for (int r = 0; r < 8; r++)
			send_instr(enc_imm(OPC_ADD, 3'(r), 3'(r), 5'(rand_bits(5))));
		wait_drain();
		report_test("immediate loads");

		for (int i = 0; i < 8; i++)
			send_instr(enc_imm(OPC_ADD, 3'd1, 3'd1, 5'd1));
		for (int i = 0; i < 8; i++)
			send_instr(enc_reg(OPC_ADD, 3'd2, 3'd1, 3'd2));
		// Gap of 1 meets the producer on the CDB, gap of 2 finds it done in the ROB
		for (int i = 0; i < 8; i++)
		begin
			send_instr(enc_imm(OPC_ADD, 3'd3, 3'd2, 5'(i)));
			wait_cycles(i % 3);
			send_instr(enc_reg(OPC_AND, 3'd4, 3'd3, 3'd1));
		end
		wait_drain();
		report_test("dependency chains");

		run_mix();
		wait_drain();
		report_test("opcode mix");

		// Long chain on R5 interleaved with independent writes of R6
		for (int i = 0; i < N_ORDER / 2; i++)
		begin
			send_instr(enc_reg(OPC_ADD, 3'd5, 3'd5, 3'd1));
			send_instr(enc_imm(OPC_AND, 3'd6, 3'd0, 5'(i)));
		end
		wait_drain();
		report_test("program order");

		stall_seen = 1'b0;
		for (int i = 0; i < N_BURST; i++)
			send_instr(enc_reg(OPC_ADD, 3'(1 + rand_bits(1)), 3'(1 + rand_bits(1)),
				3'(1 + rand_bits(1))));
		wait_drain();
		assert (stall_seen)
		else
		begin
			$display("Burst never raised stall");
			errors++;
		end
		assert (!stall)
		else
		begin
			$display("[ERROR] stall %h after the core drained", stall);
			errors++;
		end
		assert (commits == accepted)
		else
		begin
			$display("[ERROR] commits %h expected %h", commits, accepted);
			errors++;
		end
		report_test("back-pressure");

		$display("Summary: %0d tests, %0d instructions, %0d commits, %0d errors",
			tests, accepted, commits, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule : ooo_core_tb
